// File: Bender.yml
package:
  name: axil_cdc

sources:
  - source/axil_cdc_pkg.sv
  - source/cdc_fifo_if.sv
  - source/cdc_fifo_src.sv
  - source/cdc_fifo_dst.sv
  - source/cdc_fifo_gray.sv
  - source/axil_cdc.sv
  - target: simulation
    files:
      - tb/axil_cdc_props.sv
      - tb/tb_axil_cdc.sv

// File: sim.f
source/axil_cdc_pkg.sv
source/cdc_fifo_if.sv
source/cdc_fifo_src.sv
source/cdc_fifo_dst.sv
source/cdc_fifo_gray.sv
source/axil_cdc.sv
tb/axil_cdc_props.sv
tb/tb_axil_cdc.sv

// File: source/axil_cdc.sv
// AXI4-Lite clock domain crossing
`timescale 1ns/1ps

module axil_cdc import axil_cdc_pkg::*; (
  input  logic                 src_clk_i,
  input  logic                 dst_clk_i,
  input  logic                 arst_n_i,
  // Slave side, clocked by src_clk_i
  input  logic [AddrWidth-1:0] src_aw_addr_i,
  input  axil_prot_e           src_aw_prot_i,
  input  logic                 src_aw_valid_i,
  output logic                 src_aw_ready_o,
  input  logic [DataWidth-1:0] src_w_data_i,
  input  logic [StrbWidth-1:0] src_w_strb_i,
  input  logic                 src_w_valid_i,
  output logic                 src_w_ready_o,
  output axil_resp_e           src_b_resp_o,
  output logic                 src_b_valid_o,
  input  logic                 src_b_ready_i,
  input  logic [AddrWidth-1:0] src_ar_addr_i,
  input  axil_prot_e           src_ar_prot_i,
  input  logic                 src_ar_valid_i,
  output logic                 src_ar_ready_o,
  output logic [DataWidth-1:0] src_r_data_o,
  output axil_resp_e           src_r_resp_o,
  output logic                 src_r_valid_o,
  input  logic                 src_r_ready_i,
  // Master side, clocked by dst_clk_i
  output logic [AddrWidth-1:0] dst_aw_addr_o,
  output axil_prot_e           dst_aw_prot_o,
  output logic                 dst_aw_valid_o,
  input  logic                 dst_aw_ready_i,
  output logic [DataWidth-1:0] dst_w_data_o,
  output logic [StrbWidth-1:0] dst_w_strb_o,
  output logic                 dst_w_valid_o,
  input  logic                 dst_w_ready_i,
  input  axil_resp_e           dst_b_resp_i,
  input  logic                 dst_b_valid_i,
  output logic                 dst_b_ready_o,
  output logic [AddrWidth-1:0] dst_ar_addr_o,
  output axil_prot_e           dst_ar_prot_o,
  output logic                 dst_ar_valid_o,
  input  logic                 dst_ar_ready_i,
  input  logic [DataWidth-1:0] dst_r_data_i,
  input  axil_resp_e           dst_r_resp_i,
  input  logic                 dst_r_valid_i,
  output logic                 dst_r_ready_o
);

  // Channel payloads on each side of the crossing
  aw_chan_t src_aw, dst_aw;
  w_chan_t  src_w,  dst_w;
  b_chan_t  src_b,  dst_b;
  ar_chan_t src_ar, dst_ar;
  r_chan_t  src_r,  dst_r;

  // Pack requests on the slave side
  assign src_aw.addr = src_aw_addr_i;
  assign src_aw.prot = src_aw_prot_i;
  assign src_w.data  = src_w_data_i;
  assign src_w.strb  = src_w_strb_i;
  assign src_ar.addr = src_ar_addr_i;
  assign src_ar.prot = src_ar_prot_i;

  // Pack responses on the master side
  assign dst_b.resp = dst_b_resp_i;
  assign dst_r.data = dst_r_data_i;
  assign dst_r.resp = dst_r_resp_i;

  // AW, slave to master
  cdc_fifo_gray #(
    .WIDTH       ( $bits(aw_chan_t) )
  ) i_cdc_aw (
    .src_clk_i   ( src_clk_i        ),
    .dst_clk_i   ( dst_clk_i        ),
    .arst_n_i    ( arst_n_i         ),
    .src_data_i  ( src_aw           ),
    .src_valid_i ( src_aw_valid_i   ),
    .src_ready_o ( src_aw_ready_o   ),
    .dst_data_o  ( dst_aw           ),
    .dst_valid_o ( dst_aw_valid_o   ),
    .dst_ready_i ( dst_aw_ready_i   )
  );

  // W, slave to master
  cdc_fifo_gray #(
    .WIDTH       ( $bits(w_chan_t) )
  ) i_cdc_w (
    .src_clk_i   ( src_clk_i       ),
    .dst_clk_i   ( dst_clk_i       ),
    .arst_n_i    ( arst_n_i        ),
    .src_data_i  ( src_w           ),
    .src_valid_i ( src_w_valid_i   ),
    .src_ready_o ( src_w_ready_o   ),
    .dst_data_o  ( dst_w           ),
    .dst_valid_o ( dst_w_valid_o   ),
    .dst_ready_i ( dst_w_ready_i   )
  );

  // B runs backwards, so dst_clk_i feeds the push half
  cdc_fifo_gray #(
    .WIDTH       ( $bits(b_chan_t) )
  ) i_cdc_b (
    .src_clk_i   ( dst_clk_i       ),
    .dst_clk_i   ( src_clk_i       ),
    .arst_n_i    ( arst_n_i        ),
    .src_data_i  ( dst_b           ),
    .src_valid_i ( dst_b_valid_i   ),
    .src_ready_o ( dst_b_ready_o   ),
    .dst_data_o  ( src_b           ),
    .dst_valid_o ( src_b_valid_o   ),
    .dst_ready_i ( src_b_ready_i   )
  );

  // AR, slave to master
  cdc_fifo_gray #(
    .WIDTH       ( $bits(ar_chan_t) )
  ) i_cdc_ar (
    .src_clk_i   ( src_clk_i        ),
    .dst_clk_i   ( dst_clk_i        ),
    .arst_n_i    ( arst_n_i         ),
    .src_data_i  ( src_ar           ),
    .src_valid_i ( src_ar_valid_i   ),
    .src_ready_o ( src_ar_ready_o   ),
    .dst_data_o  ( dst_ar           ),
    .dst_valid_o ( dst_ar_valid_o   ),
    .dst_ready_i ( dst_ar_ready_i   )
  );

  // R runs backwards as well
  cdc_fifo_gray #(
    .WIDTH       ( $bits(r_chan_t) )
  ) i_cdc_r (
    .src_clk_i   ( dst_clk_i       ),
    .dst_clk_i   ( src_clk_i       ),
    .arst_n_i    ( arst_n_i        ),
    .src_data_i  ( dst_r           ),
    .src_valid_i ( dst_r_valid_i   ),
    .src_ready_o ( dst_r_ready_o   ),
    .dst_data_o  ( src_r           ),
    .dst_valid_o ( src_r_valid_o   ),
    .dst_ready_i ( src_r_ready_i   )
  );

  // Unpack requests toward the master side
  assign dst_aw_addr_o = dst_aw.addr;
  assign dst_aw_prot_o = dst_aw.prot;
  assign dst_w_data_o  = dst_w.data;
  assign dst_w_strb_o  = dst_w.strb;
  assign dst_ar_addr_o = dst_ar.addr;
  assign dst_ar_prot_o = dst_ar.prot;

  // Unpack responses toward the slave side
  assign src_b_resp_o = src_b.resp;
  assign src_r_data_o = src_r.data;
  assign src_r_resp_o = src_r.resp;

endmodule

// File: source/axil_cdc_pkg.sv
// AXI4-Lite CDC definitions
package axil_cdc_pkg;

  // AXI4-Lite bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // One strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;

  // FIFO depth, given as a power of two
  localparam int unsigned LogDepth = 2;
  localparam int unsigned Depth    = 1 << LogDepth;
  // Extra wrap bit tells full from empty
  localparam int unsigned PtrWidth = LogDepth + 1;

  // Gray pointers differ only in the top two bits when the FIFO is full
  localparam logic [PtrWidth-1:0] GrayFullMask = {2'b11, {(PtrWidth-2){1'b0}}};

  // Response codes of the B and R channels
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // Protection codes, bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef enum logic [2:0] {
    PROT_DATA_SEC_UNPRIV  = 3'b000,
    PROT_DATA_SEC_PRIV    = 3'b001,
    PROT_DATA_NSEC_UNPRIV = 3'b010,
    PROT_DATA_NSEC_PRIV   = 3'b011,
    PROT_INSN_SEC_UNPRIV  = 3'b100,
    PROT_INSN_SEC_PRIV    = 3'b101,
    PROT_INSN_NSEC_UNPRIV = 3'b110,
    PROT_INSN_NSEC_PRIV   = 3'b111
  } axil_prot_e;

  // Payload of each channel, valid and ready travel beside it
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    axil_prot_e           prot;
  } aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    axil_resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    axil_prot_e           prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    axil_resp_e           resp;
  } r_chan_t;

  // Binary to gray, one bit flips per increment
  function automatic logic [PtrWidth-1:0] bin2gray(input logic [PtrWidth-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

// File: source/cdc_fifo_dst.sv
// CDC FIFO pop half
`timescale 1ns/1ps

module cdc_fifo_dst import axil_cdc_pkg::*; #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i,
  cdc_fifo_if.pop          fifo
);

  // Local reset, released in step with clk_i
  logic [1:0]          rst_sync_q;
  logic                rst_n;
  // Read pointer, binary for addressing and gray for the crossing
  logic [PtrWidth-1:0] rptr_q;
  logic [PtrWidth-1:0] rptr_d;
  logic [PtrWidth-1:0] rptr_gray_q;
  // Two-flop synchronizer for the remote write pointer
  logic [PtrWidth-1:0] wptr_sync1_q;
  logic [PtrWidth-1:0] wptr_sync2_q;
  logic                empty;
  logic                pop;

  // Assert at once, release after two edges
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  // Zero matches the cleared read pointer, so the FIFO reads empty in reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_sync1_q <= '0;
      wptr_sync2_q <= '0;
    end else begin
      wptr_sync1_q <= fifo.wptr_gray;
      wptr_sync2_q <= wptr_sync1_q;
    end
  end

  // Empty when the reader has caught up with the synchronized writer
  assign empty   = wptr_sync2_q == rptr_gray_q;
  assign valid_o = ~empty;
  assign pop     = valid_o & ready_i;

  assign rptr_d = rptr_q + PtrWidth'(1);

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q      <= '0;
      rptr_gray_q <= '0;
    end else if (pop) begin
      rptr_q      <= rptr_d;
      rptr_gray_q <= bin2gray(rptr_d);
    end
  end

  // Head entry comes straight out of the push-side storage
  assign fifo.rd_addr   = rptr_q[LogDepth-1:0];
  assign fifo.rptr_gray = rptr_gray_q;
  assign data_o         = fifo.rd_data;

endmodule

// File: source/cdc_fifo_gray.sv
// Gray-pointer CDC FIFO
`timescale 1ns/1ps

module cdc_fifo_gray #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             src_clk_i,
  input  logic             dst_clk_i,
  input  logic             arst_n_i,
  // Push side, clocked by src_clk_i
  input  logic [WIDTH-1:0] src_data_i,
  input  logic             src_valid_i,
  output logic             src_ready_o,
  // Pop side, clocked by dst_clk_i
  output logic [WIDTH-1:0] dst_data_o,
  output logic             dst_valid_o,
  input  logic             dst_ready_i
);

  // Pointers and storage read port between the halves
  cdc_fifo_if #(.WIDTH(WIDTH)) fifo ();

  cdc_fifo_src #(
    .WIDTH    ( WIDTH       )
  ) i_src (
    .clk_i    ( src_clk_i   ),
    .arst_n_i ( arst_n_i    ),
    .data_i   ( src_data_i  ),
    .valid_i  ( src_valid_i ),
    .ready_o  ( src_ready_o ),
    .fifo     ( fifo.push   )
  );

  cdc_fifo_dst #(
    .WIDTH    ( WIDTH       )
  ) i_dst (
    .clk_i    ( dst_clk_i   ),
    .arst_n_i ( arst_n_i    ),
    .data_o   ( dst_data_o  ),
    .valid_o  ( dst_valid_o ),
    .ready_i  ( dst_ready_i ),
    .fifo     ( fifo.pop    )
  );

endmodule

// File: source/cdc_fifo_if.sv
// CDC FIFO half-to-half link
`timescale 1ns/1ps

interface cdc_fifo_if import axil_cdc_pkg::*; #(
  parameter int unsigned WIDTH = 8
);

  // Write pointer in gray code, from the push clock domain
  logic [PtrWidth-1:0] wptr_gray;
  // Read pointer in gray code, from the pop clock domain
  logic [PtrWidth-1:0] rptr_gray;
  // Storage read port, addressed from the pop side
  logic [LogDepth-1:0] rd_addr;
  logic [WIDTH-1:0]    rd_data;

  // Push half owns the storage and the write pointer
  modport push (
    output wptr_gray,
    output rd_data,
    input  rptr_gray,
    input  rd_addr
  );

  // Pop half owns the read pointer and the read address
  modport pop (
    output rptr_gray,
    output rd_addr,
    input  wptr_gray,
    input  rd_data
  );

endinterface

// File: source/cdc_fifo_src.sv
// CDC FIFO push half
`timescale 1ns/1ps

module cdc_fifo_src import axil_cdc_pkg::*; #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  cdc_fifo_if.push         fifo
);

  // Local reset, released in step with clk_i
  logic [1:0]          rst_sync_q;
  logic                rst_n;
  // Write pointer, binary for addressing and gray for the crossing
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] wptr_d;
  logic [PtrWidth-1:0] wptr_gray_q;
  // Two-flop synchronizer for the remote read pointer
  logic [PtrWidth-1:0] rptr_sync1_q;
  logic [PtrWidth-1:0] rptr_sync2_q;
  logic                full;
  logic                push;
  // Storage, read combinationally by the pop half
  logic [WIDTH-1:0]    mem_q [Depth];

  // Assert at once, release after two edges
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  // Synchronizer comes out of reset looking full
  // It loads the real read pointer over the same two edges as the reset sync,
  // so ready stays low until the local pointer flops are live
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_sync1_q <= GrayFullMask;
      rptr_sync2_q <= GrayFullMask;
    end else begin
      rptr_sync1_q <= fifo.rptr_gray;
      rptr_sync2_q <= rptr_sync1_q;
    end
  end

  // Full when a whole lap ahead of the reader
  assign full    = (wptr_gray_q ^ rptr_sync2_q) == GrayFullMask;
  assign ready_o = ~full;
  assign push    = valid_i & ready_o;

  assign wptr_d = wptr_q + PtrWidth'(1);

  // Gray copy moves on the push edge itself
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q      <= '0;
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_q      <= wptr_d;
      wptr_gray_q <= bin2gray(wptr_d);
    end
  end

  // Only free slots get written, so the entry under the reader stays stable
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q[LogDepth-1:0]] <= data_i;
    end
  end

  assign fifo.wptr_gray = wptr_gray_q;
  assign fifo.rd_data   = mem_q[fifo.rd_addr];

endmodule

// File: tb/axil_cdc_props.sv
// CDC FIFO assertions
`timescale 1ns/1ps

module axil_cdc_props import axil_cdc_pkg::*; #(
  parameter int unsigned WIDTH = 8
) (
  input logic                src_clk_i,
  input logic                dst_clk_i,
  input logic                arst_n_i,
  input logic [WIDTH-1:0]    src_data_i,
  input logic                src_valid_i,
  input logic                src_ready_o,
  input logic [WIDTH-1:0]    dst_data_o,
  input logic                dst_valid_o,
  input logic                dst_ready_i,
  input logic [PtrWidth-1:0] wptr_gray_i,
  input logic [PtrWidth-1:0] rptr_gray_i
);

  // Entries held right now, from the raw pointers of both halves
  logic [PtrWidth-1:0] fill;

  function automatic logic [PtrWidth-1:0] gray2bin(input logic [PtrWidth-1:0] gray);
    logic [PtrWidth-1:0] bin;
    bin[PtrWidth-1] = gray[PtrWidth-1];
    for (int i = PtrWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  assign fill = gray2bin(wptr_gray_i) - gray2bin(rptr_gray_i);

  // Stalled push side keeps its beat
  assert property (@(posedge src_clk_i) disable iff (!arst_n_i)
    src_valid_i && !src_ready_o |=> src_valid_i && $stable(src_data_i))
    else $error("push side beat changed while stalled");

  // Stalled pop side keeps its beat
  assert property (@(posedge dst_clk_i) disable iff (!arst_n_i)
    dst_valid_o && !dst_ready_i |=> dst_valid_o && $stable(dst_data_o))
    else $error("pop side beat changed while stalled");

  // Gray pointers move one bit at a time
  assert property (@(posedge src_clk_i) disable iff (!arst_n_i)
    $countones(wptr_gray_i ^ $past(wptr_gray_i)) <= 1)
    else $error("write pointer changed more than one bit");

  assert property (@(posedge dst_clk_i) disable iff (!arst_n_i)
    $countones(rptr_gray_i ^ $past(rptr_gray_i)) <= 1)
    else $error("read pointer changed more than one bit");

  // Full FIFO takes no push
  assert property (@(posedge src_clk_i) disable iff (!arst_n_i)
    fill == PtrWidth'(Depth) |-> !(src_valid_i && src_ready_o))
    else $error("push accepted while full");

endmodule

bind cdc_fifo_gray axil_cdc_props #(.WIDTH(WIDTH)) u_props (
  .src_clk_i   ( src_clk_i      ),
  .dst_clk_i   ( dst_clk_i      ),
  .arst_n_i    ( arst_n_i       ),
  .src_data_i  ( src_data_i     ),
  .src_valid_i ( src_valid_i    ),
  .src_ready_o ( src_ready_o    ),
  .dst_data_o  ( dst_data_o     ),
  .dst_valid_o ( dst_valid_o    ),
  .dst_ready_i ( dst_ready_i    ),
  .wptr_gray_i ( fifo.wptr_gray ),
  .rptr_gray_i ( fifo.rptr_gray )
);

// File: tb/tb_axil_cdc.sv
// AXI4-Lite CDC testbench
`timescale 1ns/1ps

module tb_axil_cdc import axil_cdc_pkg::*; ();

  // About 200 transactions at up to 100 source cycles each
  localparam int unsigned TimeoutCycles = 20000;

  // DUT ports carry the port names for the .* connection
  logic src_clk_i, dst_clk_i, arst_n_i;
  logic [AddrWidth-1:0] src_aw_addr_i, dst_aw_addr_o, src_ar_addr_i, dst_ar_addr_o;
  axil_prot_e src_aw_prot_i, dst_aw_prot_o, src_ar_prot_i, dst_ar_prot_o;
  logic src_aw_valid_i, src_aw_ready_o, dst_aw_valid_o, dst_aw_ready_i;
  logic [DataWidth-1:0] src_w_data_i, dst_w_data_o, src_r_data_o, dst_r_data_i;
  logic [StrbWidth-1:0] src_w_strb_i, dst_w_strb_o;
  logic src_w_valid_i, src_w_ready_o, dst_w_valid_o, dst_w_ready_i;
  axil_resp_e src_b_resp_o, dst_b_resp_i, src_r_resp_o, dst_r_resp_i;
  logic src_b_valid_o, src_b_ready_i, dst_b_valid_i, dst_b_ready_o;
  logic src_ar_valid_i, src_ar_ready_o, dst_ar_valid_o, dst_ar_ready_i;
  logic src_r_valid_o, src_r_ready_i, dst_r_valid_i, dst_r_ready_o;

  // Sent on one side, expected on the other
  aw_chan_t exp_aw_q[$], act_aw_q[$];
  w_chan_t  exp_w_q[$],  act_w_q[$];
  ar_chan_t exp_ar_q[$], act_ar_q[$];
  b_chan_t  exp_b_q[$],  act_b_q[$];
  r_chan_t  exp_r_q[$],  act_r_q[$];
  // Slave model bookkeeping
  logic [AddrWidth-1:0] slv_aw_q[$], slv_ar_q[$];
  int     slv_w_cnt;
  integer seed = 32'h58b1;
  bit     stall;
  bit     hold_aw;
  int     aw_sent;
  int     cycles;
  string  test_name;

  axil_cdc u_dut (.*);

  initial begin
    src_clk_i = 1'b0;
    forever #2 src_clk_i = ~src_clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #3.5 dst_clk_i = ~dst_clk_i;
  end

  // Read data is the address XOR A5A5_0000 and the upper half answers SLVERR
  function automatic r_chan_t ref_resp(input logic [AddrWidth-1:0] addr);
    r_chan_t r;
    r.data = addr ^ 32'hA5A5_0000;
    r.resp = addr[31] ? RESP_SLVERR : RESP_OKAY;
    return r;
  endfunction

  task automatic fail_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_aw(input string ch, input aw_chan_t exp, input aw_chan_t act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, ch, exp, act);
      fail_run();
    end
  endtask

  task automatic check_w(input string ch, input w_chan_t exp, input w_chan_t act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, ch, exp, act);
      fail_run();
    end
  endtask

  task automatic check_ar(input string ch, input ar_chan_t exp, input ar_chan_t act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, ch, exp, act);
      fail_run();
    end
  endtask

  task automatic check_b(input string ch, input b_chan_t exp, input b_chan_t act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %s, actual %s", test_name, ch, exp.resp.name(),
               act.resp.name());
      fail_run();
    end
  endtask

  task automatic check_r(input string ch, input r_chan_t exp, input r_chan_t act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, ch, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, sig, exp, act);
      fail_run();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic no_beat(input string ch);
    $display("%s: a beat arrived on the %s channel with nothing queued", test_name, ch);
    fail_run();
  endtask

  // Compare everything that arrived since the last edge
  task automatic compare_all();
    while (act_aw_q.size() != 0) begin
      if (exp_aw_q.size() == 0) no_beat("AW");
      check_aw("aw", exp_aw_q.pop_front(), act_aw_q.pop_front());
    end
    while (act_w_q.size() != 0) begin
      if (exp_w_q.size() == 0) no_beat("W");
      check_w("w", exp_w_q.pop_front(), act_w_q.pop_front());
    end
    while (act_ar_q.size() != 0) begin
      if (exp_ar_q.size() == 0) no_beat("AR");
      check_ar("ar", exp_ar_q.pop_front(), act_ar_q.pop_front());
    end
    while (act_b_q.size() != 0) begin
      if (exp_b_q.size() == 0) no_beat("B");
      check_b("b", exp_b_q.pop_front(), act_b_q.pop_front());
    end
    while (act_r_q.size() != 0) begin
      if (exp_r_q.size() == 0) no_beat("R");
      check_r("r", exp_r_q.pop_front(), act_r_q.pop_front());
    end
  endtask

  // Rising edges see the queues that the falling-edge models have settled
  always @(posedge src_clk_i or posedge dst_clk_i) begin
    compare_all();
  end

  always @(posedge src_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d source cycles, traffic stopped moving", cycles);
      fail_run();
    end
  end

  function automatic bit pick_ready();
    int unsigned n;
    n = $random(seed);
    return !stall || (n % 4 != 0);
  endfunction

  task automatic gap_src();
    int unsigned n;
    n = $random(seed);
    if (stall) repeat (n % 4) @(negedge src_clk_i);
  endtask

  task automatic gap_dst();
    int unsigned n;
    n = $random(seed);
    if (stall) repeat (n % 4) @(negedge dst_clk_i);
  endtask

  // Master side drivers enter and leave on a falling edge
  task automatic drive_aw(input aw_chan_t beat);
    src_aw_addr_i  = beat.addr;
    src_aw_prot_i  = beat.prot;
    src_aw_valid_i = 1'b1;
    while (!src_aw_ready_o) @(negedge src_clk_i);
    @(negedge src_clk_i);
    aw_sent++;
    src_aw_valid_i = 1'b0;
  endtask

  task automatic drive_w(input w_chan_t beat);
    {src_w_data_i, src_w_strb_i} = beat;
    src_w_valid_i = 1'b1;
    while (!src_w_ready_o) @(negedge src_clk_i);
    @(negedge src_clk_i);
    src_w_valid_i = 1'b0;
  endtask

  task automatic drive_ar(input ar_chan_t beat);
    src_ar_addr_i  = beat.addr;
    src_ar_prot_i  = beat.prot;
    src_ar_valid_i = 1'b1;
    while (!src_ar_ready_o) @(negedge src_clk_i);
    @(negedge src_clk_i);
    src_ar_valid_i = 1'b0;
  endtask

  task automatic take_b();
    src_b_ready_i = pick_ready();
    while (!(src_b_ready_i && src_b_valid_o)) begin
      @(negedge src_clk_i);
      src_b_ready_i = pick_ready();
    end
    act_b_q.push_back(b_chan_t'(src_b_resp_o));
    @(negedge src_clk_i);
    src_b_ready_i = 1'b0;
  endtask

  task automatic take_r();
    src_r_ready_i = pick_ready();
    while (!(src_r_ready_i && src_r_valid_o)) begin
      @(negedge src_clk_i);
      src_r_ready_i = pick_ready();
    end
    act_r_q.push_back({src_r_data_o, src_r_resp_o});
    @(negedge src_clk_i);
    src_r_ready_i = 1'b0;
  endtask

  // Slave side model on the destination clock
  task automatic slave_aw();
    dst_aw_ready_i = hold_aw ? 1'b0 : pick_ready();
    while (!(dst_aw_ready_i && dst_aw_valid_o)) begin
      @(negedge dst_clk_i);
      dst_aw_ready_i = hold_aw ? 1'b0 : pick_ready();
    end
    act_aw_q.push_back({dst_aw_addr_o, dst_aw_prot_o});
    slv_aw_q.push_back(dst_aw_addr_o);
    @(negedge dst_clk_i);
    dst_aw_ready_i = 1'b0;
  endtask

  task automatic slave_w();
    dst_w_ready_i = pick_ready();
    while (!(dst_w_ready_i && dst_w_valid_o)) begin
      @(negedge dst_clk_i);
      dst_w_ready_i = pick_ready();
    end
    act_w_q.push_back({dst_w_data_o, dst_w_strb_o});
    slv_w_cnt++;
    @(negedge dst_clk_i);
    dst_w_ready_i = 1'b0;
  endtask

  task automatic slave_ar();
    dst_ar_ready_i = pick_ready();
    while (!(dst_ar_ready_i && dst_ar_valid_o)) begin
      @(negedge dst_clk_i);
      dst_ar_ready_i = pick_ready();
    end
    act_ar_q.push_back({dst_ar_addr_o, dst_ar_prot_o});
    slv_ar_q.push_back(dst_ar_addr_o);
    @(negedge dst_clk_i);
    dst_ar_ready_i = 1'b0;
  endtask

  // A write is answered once both its address and data have arrived
  task automatic slave_b();
    r_chan_t ans;
    while (slv_aw_q.size() == 0 || slv_w_cnt == 0) @(negedge dst_clk_i);
    gap_dst();
    ans = ref_resp(slv_aw_q.pop_front());
    slv_w_cnt--;
    dst_b_resp_i  = ans.resp;
    dst_b_valid_i = 1'b1;
    while (!dst_b_ready_o) @(negedge dst_clk_i);
    @(negedge dst_clk_i);
    dst_b_valid_i = 1'b0;
  endtask

  task automatic slave_r();
    r_chan_t ans;
    while (slv_ar_q.size() == 0) @(negedge dst_clk_i);
    gap_dst();
    ans = ref_resp(slv_ar_q.pop_front());
    dst_r_data_i  = ans.data;
    dst_r_resp_i  = ans.resp;
    dst_r_valid_i = 1'b1;
    while (!dst_r_ready_o) @(negedge dst_clk_i);
    @(negedge dst_clk_i);
    dst_r_valid_i = 1'b0;
  endtask

  // Runs n writes and n reads with all models in parallel
  task automatic run_traffic(input int n);
    aw_chan_t aw[$];
    w_chan_t  w[$];
    ar_chan_t ar[$];
    aw_chan_t a;
    w_chan_t  d;
    ar_chan_t q;
    r_chan_t  ans;
    b_chan_t  b;
    aw_sent = 0;
    for (int i = 0; i < n; i++) begin
      a.addr = $random(seed);
      a.prot = axil_prot_e'(3'($random(seed)));
      d.data = $random(seed);
      d.strb = 4'($random(seed));
      q.addr = $random(seed);
      q.prot = axil_prot_e'(3'($random(seed)));
      aw.push_back(a);
      w.push_back(d);
      ar.push_back(q);
      exp_aw_q.push_back(a);
      exp_w_q.push_back(d);
      exp_ar_q.push_back(q);
      ans = ref_resp(a.addr);
      b.resp = ans.resp;
      exp_b_q.push_back(b);
      exp_r_q.push_back(ref_resp(q.addr));
    end
    fork
      begin
        @(negedge src_clk_i);
        foreach (aw[i]) begin
          gap_src();
          drive_aw(aw[i]);
        end
      end
      begin
        @(negedge src_clk_i);
        foreach (w[i]) begin
          gap_src();
          drive_w(w[i]);
        end
      end
      begin
        @(negedge src_clk_i);
        foreach (ar[i]) begin
          gap_src();
          drive_ar(ar[i]);
        end
      end
      begin
        @(negedge src_clk_i);
        repeat (n) take_b();
      end
      begin
        @(negedge src_clk_i);
        repeat (n) take_r();
      end
      begin
        @(negedge dst_clk_i);
        repeat (n) slave_aw();
      end
      begin
        @(negedge dst_clk_i);
        repeat (n) slave_w();
      end
      begin
        @(negedge dst_clk_i);
        repeat (n) slave_ar();
      end
      begin
        @(negedge dst_clk_i);
        repeat (n) slave_b();
      end
      begin
        @(negedge dst_clk_i);
        repeat (n) slave_r();
      end
    join
    repeat (2) @(posedge src_clk_i);
    check_count("missing AW beats", 0, exp_aw_q.size());
    check_count("missing W beats", 0, exp_w_q.size());
    check_count("missing AR beats", 0, exp_ar_q.size());
    check_count("missing B beats", 0, exp_b_q.size());
    check_count("missing R beats", 0, exp_r_q.size());
  endtask

  task automatic check_valids_low();
    check_bit("dst_aw_valid_o", 1'b0, dst_aw_valid_o);
    check_bit("dst_w_valid_o", 1'b0, dst_w_valid_o);
    check_bit("dst_ar_valid_o", 1'b0, dst_ar_valid_o);
    check_bit("src_b_valid_o", 1'b0, src_b_valid_o);
    check_bit("src_r_valid_o", 1'b0, src_r_valid_o);
  endtask

  task automatic check_readies_low();
    check_bit("src_aw_ready_o", 1'b0, src_aw_ready_o);
    check_bit("src_w_ready_o", 1'b0, src_w_ready_o);
    check_bit("src_ar_ready_o", 1'b0, src_ar_ready_o);
    check_bit("dst_b_ready_o", 1'b0, dst_b_ready_o);
    check_bit("dst_r_ready_o", 1'b0, dst_r_ready_o);
  endtask

  initial begin
    src_aw_addr_i  = '0;
    src_aw_prot_i  = PROT_DATA_SEC_UNPRIV;
    src_aw_valid_i = 1'b0;
    {src_w_data_i, src_w_strb_i, src_w_valid_i} = '0;
    src_ar_addr_i  = '0;
    src_ar_prot_i  = PROT_DATA_SEC_UNPRIV;
    src_ar_valid_i = 1'b0;
    {src_b_ready_i, src_r_ready_i} = '0;
    {dst_aw_ready_i, dst_w_ready_i, dst_ar_ready_i} = '0;
    dst_b_resp_i   = RESP_OKAY;
    dst_b_valid_i  = 1'b0;
    dst_r_data_i   = '0;
    dst_r_resp_i   = RESP_OKAY;
    dst_r_valid_i  = 1'b0;
    arst_n_i  = 1'b0;
    slv_w_cnt = 0;
    cycles    = 0;
    stall     = 1'b0;
    hold_aw   = 1'b0;

    test_name = "reset";
    repeat (5) begin
      @(negedge src_clk_i);
      check_valids_low();
      check_readies_low();
    end
    arst_n_i = 1'b1;
    // Ready rises only once both halves of every FIFO left reset
    while (!(src_aw_ready_o && src_w_ready_o && src_ar_ready_o &&
             dst_b_ready_o && dst_r_ready_o)) begin
      @(negedge src_clk_i);
      check_valids_low();
    end

    test_name = "request and response crossing";
    run_traffic(50);

    test_name = "back-pressure";
    hold_aw = 1'b1;
    aw_sent = 0;
    fork
      run_traffic(6);
      begin
        while (aw_sent < 4) @(negedge src_clk_i);
        repeat (20) @(negedge src_clk_i);
        check_count("AW beats accepted", 4, aw_sent);
        check_bit("src_aw_ready_o", 1'b0, src_aw_ready_o);
        hold_aw = 1'b0;
      end
    join

    test_name = "random stalls";
    stall = 1'b1;
    run_traffic(50);

    // Nothing left over on any channel
    test_name = "idle";
    repeat (20) @(negedge dst_clk_i);
    check_valids_low();

    $display("all tests passed");
    $finish;
  end

endmodule
